//--- rtl/micro_expand_params.svh
// Shared constants for the macro-instruction expander
// Include in any file that needs widths, register numbers or ROM entry points
// Register numbers are sized to the register field of the instruction word

`ifndef MICRO_EXPAND_PARAMS_SVH
`define MICRO_EXPAND_PARAMS_SVH

// ============================================================
// Field widths
// ============================================================
`define ME_UPC_W 5      // Micro address width, address 0 is idle or end
`define ME_OPC_W 7      // Opcode field
`define ME_REG_W 6      // Register number field
`define ME_IMM_W 16     // Immediate or displacement field
`define ME_CNT_W 3      // Register count of PUSH and POP

// Fixed register numbers
`define ME_REG_SP  6'd62  // Stack pointer
`define ME_REG_FP  6'd61  // Frame pointer
`define ME_REG_LR0 6'd56  // Link register

// Stack frame layout
`define ME_FRAME_BYTES 64  // Fixed frame area set up by ENTER
`define ME_SLOT_BYTES  16  // One register slot
`define ME_MAX_REGS    4   // Registers moved by one PUSH or POP

// ============================================================
// Micro-code entry points
// ============================================================
`define ME_ENT_ENTER 1
`define ME_ENT_LEAVE 8
`define ME_ENT_PUSH  16
`define ME_ENT_POP   24

`endif

//--- rtl/micro_expand_pkg.sv
// Types shared by the expander RTL and its testbench
// Holds the opcode set and the two decodings of a 40-bit instruction word

`default_nettype none

`include "micro_expand_params.svh"

package micro_expand_pkg;

  // Plain opcodes pass through, macro opcodes go to the micro-code ROM
  typedef enum logic [`ME_OPC_W-1:0] {
    OP_NOP   = 7'd0,
    OP_ADDI  = 7'd1,   // rt = ra + imm
    OP_MOV   = 7'd2,   // rt = ra
    OP_LDO   = 7'd3,   // rt = mem[ra + imm]
    OP_STO   = 7'd4,   // mem[ra + imm] = rt
    OP_JSR   = 7'd5,   // Jump to ra + imm, link in rt
    OP_ENTER = 7'd8,
    OP_LEAVE = 7'd9,
    OP_PUSH  = 7'd10,
    OP_POP   = 7'd11
  } opcode_e;

  // Register and immediate form, also used by ENTER and LEAVE
  typedef struct packed {
    logic [4:0]               pad;     // Spare
    logic [`ME_IMM_W-1:0]     imm;     // Bits 34..19
    logic [`ME_REG_W-1:0]     ra;
    logic [`ME_REG_W-1:0]     rt;
    opcode_e                  opcode;
  } ri_t;

  // Register list form of PUSH and POP
  typedef struct packed {
    logic [5:0]               pad;     // Spare
    logic [`ME_CNT_W-1:0]     cnt;     // Bits 33..31
    logic [`ME_REG_W-1:0]     rc;
    logic [`ME_REG_W-1:0]     rb;
    logic [`ME_REG_W-1:0]     ra;
    logic [`ME_REG_W-1:0]     rs;
    opcode_e                  opcode;
  } list_t;

  // Same 40 bits seen two ways, opcode sits in bits 6..0 in both
  typedef union packed {
    ri_t   ri;
    list_t lst;
  } instr_t;

endpackage

`default_nettype wire

//--- rtl/dec_if.sv
// Link from the decode stage to the micro sequencer
// Decode drives through the dec modport, the sequencer answers through seq

`timescale 1ns/1ps
`default_nettype none

`include "micro_expand_params.svh"

interface dec_if
  import micro_expand_pkg::*;
();

  logic                 valid;     // Decoded item present
  logic                 ready;     // Sequencer takes it this cycle
  instr_t               instr;     // Macro word, count already clamped
  logic                 is_macro;  // Expand through the ROM
  logic [`ME_UPC_W-1:0] entry;     // ROM start address

  modport dec (output valid, instr, is_macro, entry, input ready);
  modport seq (input valid, instr, is_macro, entry, output ready);

endinterface

`default_nettype wire

//--- rtl/macro_decode.sv
// Decode stage of the expander
// One-entry pipeline register in front of the sequencer. Classifies each
// instruction, picks its micro-code entry point and clamps PUSH/POP counts

`timescale 1ns/1ps
`default_nettype none

`include "micro_expand_params.svh"

module macro_decode
  import micro_expand_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   rst_n,
  input  wire logic   in_valid,
  output logic        in_ready,
  input  wire instr_t in_instr,
  dec_if.dec          dec
);

  logic                 ready_en;    // Set once reset is released
  logic                 valid_q;     // Register holds an item
  logic                 is_macro_q;
  logic [`ME_UPC_W-1:0] entry_q;
  instr_t               instr_q;     // Payload
  logic                 take;        // Input transfer
  logic                 nxt_macro;
  logic [`ME_UPC_W-1:0] nxt_entry;
  instr_t               nxt_instr;

  assign in_ready = ready_en & (~valid_q | dec.ready);  // Empty or being emptied
  assign take     = in_valid & in_ready;

  // Classify by opcode
  always_comb begin
    nxt_instr = in_instr;
    nxt_macro = 1'b1;
    nxt_entry = '0;
    case (in_instr.ri.opcode)
      OP_ENTER: nxt_entry = `ME_UPC_W'(`ME_ENT_ENTER);
      OP_LEAVE: nxt_entry = `ME_UPC_W'(`ME_ENT_LEAVE);
      OP_PUSH:  nxt_entry = `ME_UPC_W'(`ME_ENT_PUSH);
      OP_POP:   nxt_entry = `ME_UPC_W'(`ME_ENT_POP);
      default:  nxt_macro = 1'b0;         // Plain op, single micro-op
    endcase
    // Counts 5..7 act as a full list
    if ((in_instr.lst.opcode == OP_PUSH || in_instr.lst.opcode == OP_POP) &&
        in_instr.lst.cnt > `ME_CNT_W'(`ME_MAX_REGS))
      nxt_instr.lst.cnt = `ME_CNT_W'(`ME_MAX_REGS);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_en   <= 1'b0;
      valid_q    <= 1'b0;
      is_macro_q <= 1'b0;
      entry_q    <= '0;
    end else begin
      ready_en <= 1'b1;
      if (take) begin
        valid_q    <= 1'b1;
        is_macro_q <= nxt_macro;
        entry_q    <= nxt_entry;
      end else if (dec.ready) begin
        valid_q <= 1'b0;                  // Handed to the sequencer
      end
    end
  end

  always_ff @(posedge clk)
    if (take) instr_q <= nxt_instr;

  assign dec.valid    = valid_q;
  assign dec.instr    = instr_q;
  assign dec.is_macro = is_macro_q;
  assign dec.entry    = entry_q;

endmodule

`default_nettype wire

//--- rtl/micro_code_rom.sv
// Micro-code table for the macro instructions
// Pure combinational. Given the micro address and the macro word it returns
// the micro-op for that step and the address of the next step, 0 at the end

`timescale 1ns/1ps
`default_nettype none

`include "micro_expand_params.svh"

module micro_code_rom
  import micro_expand_pkg::*;
(
  input  wire logic [`ME_UPC_W-1:0] micro_ip,
  input  wire instr_t               micro_ir,
  output logic [`ME_UPC_W-1:0]      next_ip,
  output instr_t                    instr
);

  logic [`ME_CNT_W-1:0] cnt_n;    // N, already clamped
  logic [`ME_IMM_W-1:0] frame_k;  // K from the ri view
  logic [`ME_IMM_W-1:0] list_sz;  // 16N

  // Micro address of a step within a sequence
  function automatic logic [`ME_UPC_W-1:0] ua(input int base, input int step);
    return `ME_UPC_W'(base + step);
  endfunction

  // Build a micro-op in the ri form
  function automatic instr_t mk(input opcode_e op, input logic [`ME_REG_W-1:0] rt,
                                input logic [`ME_REG_W-1:0] ra,
                                input logic [`ME_IMM_W-1:0] imm);
    instr_t u;
    u           = '0;
    u.ri.imm    = imm;
    u.ri.ra     = ra;
    u.ri.rt     = rt;
    u.ri.opcode = op;
    return u;
  endfunction

  // Register slot of PUSH/POP, a NOP when outside the list
  function automatic instr_t slot(input opcode_e op, input logic [`ME_REG_W-1:0] r,
                                  input logic used, input logic [`ME_CNT_W-1:0] pos);
    if (used)
      return mk(op, r, `ME_REG_SP, `ME_IMM_W'(pos) * `ME_IMM_W'(`ME_SLOT_BYTES));
    return mk(OP_NOP, '0, '0, '0);
  endfunction

  assign cnt_n   = micro_ir.lst.cnt;
  assign frame_k = micro_ir.ri.imm;
  assign list_sz = `ME_IMM_W'(cnt_n) * `ME_IMM_W'(`ME_SLOT_BYTES);

  always_comb begin
    next_ip = micro_ip + 1'b1;            // Most steps fall through
    instr   = mk(OP_NOP, '0, '0, '0);
    case (micro_ip)
      // ============================================================
      // ENTER
      // ============================================================
      ua(`ME_ENT_ENTER, 0): instr = mk(OP_ADDI, `ME_REG_SP, `ME_REG_SP,
                                       -`ME_IMM_W'(`ME_FRAME_BYTES));       // SP -= 64
      ua(`ME_ENT_ENTER, 1): instr = mk(OP_STO, `ME_REG_FP, `ME_REG_SP, '0);  // [SP] = FP
      ua(`ME_ENT_ENTER, 2): instr = mk(OP_STO, `ME_REG_LR0, `ME_REG_SP,
                                       `ME_IMM_W'(`ME_SLOT_BYTES));         // [SP+16] = LR0
      ua(`ME_ENT_ENTER, 3): instr = mk(OP_MOV, `ME_REG_FP, `ME_REG_SP, '0);  // FP = SP
      ua(`ME_ENT_ENTER, 4): begin
        instr   = mk(OP_ADDI, `ME_REG_SP, `ME_REG_SP, -frame_k);           // Locals
        next_ip = '0;
      end
      // ============================================================
      // LEAVE
      // ============================================================
      ua(`ME_ENT_LEAVE, 0): instr = mk(OP_MOV, `ME_REG_SP, `ME_REG_FP, '0);  // SP = FP
      ua(`ME_ENT_LEAVE, 1): instr = mk(OP_LDO, `ME_REG_FP, `ME_REG_SP, '0);  // FP = [SP]
      ua(`ME_ENT_LEAVE, 2): instr = mk(OP_LDO, `ME_REG_LR0, `ME_REG_SP,
                                       `ME_IMM_W'(`ME_SLOT_BYTES));         // LR0 = [SP+16]
      ua(`ME_ENT_LEAVE, 3): instr = mk(OP_ADDI, `ME_REG_SP, `ME_REG_SP,
                                       `ME_IMM_W'(`ME_FRAME_BYTES));        // SP += 64
      ua(`ME_ENT_LEAVE, 4): instr = mk(OP_ADDI, `ME_REG_SP, `ME_REG_SP, frame_k);
      ua(`ME_ENT_LEAVE, 5): begin
        instr   = mk(OP_JSR, '0, `ME_REG_LR0, '0);                         // Return via LR0
        next_ip = '0;
      end
      // ============================================================
      // PUSH, highest slot first, slot i stored at 16*(N-1-i)
      // ============================================================
      ua(`ME_ENT_PUSH, 0): instr = mk(OP_ADDI, `ME_REG_SP, `ME_REG_SP, -list_sz);
      ua(`ME_ENT_PUSH, 1): instr = slot(OP_STO, micro_ir.lst.rc, cnt_n > 3'd3, cnt_n - 3'd4);
      ua(`ME_ENT_PUSH, 2): instr = slot(OP_STO, micro_ir.lst.rb, cnt_n > 3'd2, cnt_n - 3'd3);
      ua(`ME_ENT_PUSH, 3): instr = slot(OP_STO, micro_ir.lst.ra, cnt_n > 3'd1, cnt_n - 3'd2);
      ua(`ME_ENT_PUSH, 4): begin
        instr   = slot(OP_STO, micro_ir.lst.rs, cnt_n > 3'd0, cnt_n - 3'd1);
        next_ip = '0;
      end
      // POP, lowest slot first, then release the area
      ua(`ME_ENT_POP, 0): instr = slot(OP_LDO, micro_ir.lst.rs, cnt_n > 3'd0, 3'd0);
      ua(`ME_ENT_POP, 1): instr = slot(OP_LDO, micro_ir.lst.ra, cnt_n > 3'd1, 3'd1);
      ua(`ME_ENT_POP, 2): instr = slot(OP_LDO, micro_ir.lst.rb, cnt_n > 3'd2, 3'd2);
      ua(`ME_ENT_POP, 3): instr = slot(OP_LDO, micro_ir.lst.rc, cnt_n > 3'd3, 3'd3);
      ua(`ME_ENT_POP, 4): begin
        instr   = mk(OP_ADDI, `ME_REG_SP, `ME_REG_SP, list_sz);            // SP += 16N
        next_ip = '0;
      end
      default: next_ip = '0;              // Unused address, NOP and stop
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/micro_sequencer.sv
// Micro sequencer of the expander
// Takes decoded items, walks the micro-code ROM for macros and emits one
// micro-op per accepted cycle. Plain items leave as a single micro-op

`timescale 1ns/1ps
`default_nettype none

`include "micro_expand_params.svh"

module micro_sequencer
  import micro_expand_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  dec_if.seq        dec,
  output logic      uop_valid,
  input  wire logic uop_ready,
  output instr_t    uop_instr
);

  logic [`ME_UPC_W-1:0] upc;        // Current micro address
  logic [`ME_UPC_W-1:0] next_ip;    // From the ROM
  instr_t               ir;         // Macro word being expanded
  instr_t               rom_instr;
  logic                 pass;       // Item is a plain op
  logic                 uop_fire;
  logic                 last;       // Current micro-op ends the item
  logic                 dec_fire;

  micro_code_rom u_rom (
    .micro_ip (upc),
    .micro_ir (ir),
    .next_ip  (next_ip),
    .instr    (rom_instr)
  );

  assign uop_fire  = uop_valid & uop_ready;
  assign last      = pass | (next_ip == '0);
  assign dec.ready = ~uop_valid | (uop_ready & last);  // Idle or finishing
  assign dec_fire  = dec.valid & dec.ready;
  assign uop_instr = pass ? ir : rom_instr;

  // ============================================================
  // Micro address and item state
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      uop_valid <= 1'b0;
      upc       <= '0;
      pass      <= 1'b0;
    end else if (dec_fire) begin
      uop_valid <= 1'b1;                              // First micro-op next cycle
      upc       <= dec.is_macro ? dec.entry : '0;
      pass      <= ~dec.is_macro;
    end else if (uop_fire) begin
      if (last) begin
        uop_valid <= 1'b0;                            // Item done, nothing queued
        upc       <= '0;
      end else begin
        upc <= next_ip;                               // Step through the ROM
      end
    end
  end

  // Macro word stays put for the whole expansion
  always_ff @(posedge clk)
    if (dec_fire) ir <= dec.instr;

endmodule

`default_nettype wire

//--- rtl/uop_output_buf.sv
// Result stage of the expander
// Two-entry FIFO between the sequencer and the output stream. NOP micro-ops
// are accepted and dropped, everything else leaves in arrival order

`timescale 1ns/1ps
`default_nettype none

module uop_output_buf
  import micro_expand_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   rst_n,
  input  wire logic   uop_valid,
  output logic        uop_ready,
  input  wire instr_t uop_instr,
  output logic        out_valid,
  input  wire logic   out_ready,
  output instr_t      out_instr
);

  instr_t     mem [2];     // Storage, no reset
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] cnt;         // Entries held, 0..2
  logic       is_nop;
  logic       push;
  logic       pop;

  assign is_nop    = (uop_instr.ri.opcode == OP_NOP);
  assign uop_ready = (cnt != 2'd2);               // Stall only when full
  assign push      = uop_valid & uop_ready & ~is_nop;
  assign pop       = out_valid & out_ready;

  assign out_valid = (cnt != 2'd0);
  assign out_instr = mem[rd_ptr];                 // Oldest entry

  // ============================================================
  // Pointers and fill level
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      cnt    <= 2'd0;
    end else begin
      if (push)
        wr_ptr <= ~wr_ptr;
      if (pop)
        rd_ptr <= ~rd_ptr;
      case ({push, pop})
        2'b10:   cnt <= cnt + 2'd1;
        2'b01:   cnt <= cnt - 2'd1;
        default: cnt <= cnt;                      // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk)
    if (push) mem[wr_ptr] <= uop_instr;

endmodule

`default_nettype wire

//--- rtl/micro_expand_top.sv
// Top level of the macro-instruction expander
// Instruction stream in, micro-op stream out, both valid/ready.
// Chain is decode, sequencer with micro-code ROM, then the output buffer

`timescale 1ns/1ps
`default_nettype none

module micro_expand_top
  import micro_expand_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   rst_n,
  // Macro instruction stream
  input  wire logic   in_valid,
  output logic        in_ready,
  input  wire instr_t in_instr,
  // Micro-op stream
  output logic        out_valid,
  input  wire logic   out_ready,
  output instr_t      out_instr
);

  logic   uop_valid;   // Sequencer to result stage
  logic   uop_ready;
  instr_t uop_instr;

  dec_if u_dec ();     // Decode to sequencer link

  macro_decode u_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_instr (in_instr),
    .dec      (u_dec.dec)
  );

  micro_sequencer u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec       (u_dec.seq),
    .uop_valid (uop_valid),
    .uop_ready (uop_ready),
    .uop_instr (uop_instr)
  );

  uop_output_buf u_obuf (
    .clk       (clk),
    .rst_n     (rst_n),
    .uop_valid (uop_valid),
    .uop_ready (uop_ready),
    .uop_instr (uop_instr),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_instr (out_instr)
  );

endmodule

`default_nettype wire

//--- sim/micro_expand_model.svh
// Reference model of the expander for the testbench
// Include inside the testbench module, after the package import.
// expand_macro() appends the micro-ops one accepted instruction must
// produce to exp_q, with empty PUSH/POP slots already left out

`ifndef MICRO_EXPAND_MODEL_SVH
`define MICRO_EXPAND_MODEL_SVH

instr_t exp_q[$];   // Expected output stream, oldest first

// Micro-op in register/immediate form
function automatic instr_t uop_word(input opcode_e op, input logic [5:0] rt,
                                   input logic [5:0] ra, input logic [15:0] imm);
  instr_t u;
  u           = '0;
  u.ri.opcode = op;
  u.ri.rt     = rt;
  u.ri.ra     = ra;
  u.ri.imm    = imm;
  return u;
endfunction

task automatic expand_macro(input instr_t w);
  int          n;        // Clamped register count
  logic [15:0] k;        // Frame size of ENTER/LEAVE
  logic [5:0]  regs [4]; // List slots by index
  k       = w.ri.imm;
  n       = (w.lst.cnt > 3'd4) ? 4 : int'(w.lst.cnt);
  regs[0] = w.lst.rs;
  regs[1] = w.lst.ra;
  regs[2] = w.lst.rb;
  regs[3] = w.lst.rc;
  case (w.ri.opcode)
    OP_ENTER: begin
      exp_q.push_back(uop_word(OP_ADDI, `ME_REG_SP, `ME_REG_SP, -16'(`ME_FRAME_BYTES)));
      exp_q.push_back(uop_word(OP_STO, `ME_REG_FP, `ME_REG_SP, 16'd0));
      exp_q.push_back(uop_word(OP_STO, `ME_REG_LR0, `ME_REG_SP, 16'(`ME_SLOT_BYTES)));
      exp_q.push_back(uop_word(OP_MOV, `ME_REG_FP, `ME_REG_SP, 16'd0));
      exp_q.push_back(uop_word(OP_ADDI, `ME_REG_SP, `ME_REG_SP, -k));
    end
    OP_LEAVE: begin
      exp_q.push_back(uop_word(OP_MOV, `ME_REG_SP, `ME_REG_FP, 16'd0));
      exp_q.push_back(uop_word(OP_LDO, `ME_REG_FP, `ME_REG_SP, 16'd0));
      exp_q.push_back(uop_word(OP_LDO, `ME_REG_LR0, `ME_REG_SP, 16'(`ME_SLOT_BYTES)));
      exp_q.push_back(uop_word(OP_ADDI, `ME_REG_SP, `ME_REG_SP, 16'(`ME_FRAME_BYTES)));
      exp_q.push_back(uop_word(OP_ADDI, `ME_REG_SP, `ME_REG_SP, k));
      exp_q.push_back(uop_word(OP_JSR, 6'd0, `ME_REG_LR0, 16'd0));   // Return
    end
    OP_PUSH: begin
      exp_q.push_back(uop_word(OP_ADDI, `ME_REG_SP, `ME_REG_SP, -16'(`ME_SLOT_BYTES * n)));
      for (int idx = 3; idx >= 0; idx--)           // rc first, rs last
        if (idx < n)
          exp_q.push_back(uop_word(OP_STO, regs[idx], `ME_REG_SP,
                                   16'(`ME_SLOT_BYTES * (n - 1 - idx))));
    end
    OP_POP: begin
      for (int idx = 0; idx < 4; idx++)            // rs first, rc last
        if (idx < n)
          exp_q.push_back(uop_word(OP_LDO, regs[idx], `ME_REG_SP,
                                   16'(`ME_SLOT_BYTES * idx)));
      exp_q.push_back(uop_word(OP_ADDI, `ME_REG_SP, `ME_REG_SP, 16'(`ME_SLOT_BYTES * n)));
    end
    default:
      if (w.ri.opcode != OP_NOP) exp_q.push_back(w);   // Plain op unchanged
  endcase
endtask

`endif

//--- sim/tb_micro_expand.sv
// Testbench of the macro-instruction expander
// Sends random plain and macro instructions with idle gaps, throttles the
// output with random out_ready and checks every micro-op against the model

`timescale 1ns/1ps
`default_nettype none

`include "micro_expand_params.svh"

module tb_micro_expand
  import micro_expand_pkg::*;
();

  localparam int NUM_INSTR      = 300;
  localparam int MAX_UOPS       = 6;                            // LEAVE is longest
  localparam int TIMEOUT_CYCLES = NUM_INSTR * MAX_UOPS * 4 + 200;  // Slack for stalls
  localparam logic [31:0] SEED  = 32'h2de9_d531;

  logic   clk;
  logic   rst_n;
  logic   in_valid;
  logic   in_ready;
  instr_t in_instr;
  logic   out_valid;
  logic   out_ready;
  instr_t out_instr;

  int     gap;          // Idle cycles before the next instruction
  int     n_out  = 0;   // Micro-ops checked so far
  int     cycles = 0;

  `include "micro_expand_model.svh"

  micro_expand_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_instr  (in_instr),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_instr (out_instr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;   // 40 ns period
  end

  // ============================================================
  // Compare tasks
  // ============================================================
  task automatic check_uop(input instr_t got, input instr_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: micro-op %0d is %h (opcode %0d), expected %h (opcode %0d)",
               $time, n_out, got, got.ri.opcode, exp, exp.ri.opcode);
      $display("Verification failed");
      $fatal(1, "micro-op mismatch");
    end
  endtask

  task automatic check_idle(input logic exp_in_ready);
    if (out_valid !== 1'b0 || in_ready !== exp_in_ready) begin
      $display("** Error at %0t: idle out_valid=%b in_ready=%b, expected 0 and %b",
               $time, out_valid, in_ready, exp_in_ready);
      $display("Verification failed");
      $fatal(1, "wrong idle state");
    end
  endtask

  // Half macros and half plain ops with other fields random
  function automatic instr_t random_instr();
    instr_t      w;
    logic [39:0] raw;
    int          sel;
    raw[31:0]  = $urandom();
    raw[39:32] = 8'($urandom());
    w          = raw;                      // Count 0..7 and K come from here
    if ($urandom_range(1) == 1) begin
      sel = $urandom_range(3);
      case (sel)
        0:       w.ri.opcode = OP_ENTER;
        1:       w.ri.opcode = OP_LEAVE;
        2:       w.ri.opcode = OP_PUSH;
        default: w.ri.opcode = OP_POP;
      endcase
    end else begin
      sel = $urandom_range(5);
      case (sel)
        0:       w.ri.opcode = OP_NOP;     // Must vanish
        1:       w.ri.opcode = OP_ADDI;
        2:       w.ri.opcode = OP_MOV;
        3:       w.ri.opcode = OP_LDO;
        4:       w.ri.opcode = OP_STO;
        default: w.ri.opcode = OP_JSR;
      endcase
    end
    return w;
  endfunction

  // ============================================================
  // Monitor sampled at the falling edge where everything is settled
  // ============================================================
  always @(negedge clk) begin
    if (rst_n) begin
      if (out_valid && out_ready) begin    // Transfer at the next rising edge
        if (exp_q.size() == 0) begin
          $display("** Error at %0t: micro-op %h arrived with none expected",
                   $time, out_instr);
          $display("Verification failed");
          $fatal(1, "unexpected output");
        end else begin
          check_uop(out_instr, exp_q.pop_front());
          n_out++;
        end
      end
      if (in_valid && in_ready)
        expand_macro(in_instr);            // Fill the expected queue
    end
  end

  // Output back-pressure of about 70% ready
  always @(posedge clk) begin
    #2;
    if (rst_n)
      out_ready = ($urandom_range(9) < 7);
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $fatal(1, "simulation limit reached");
    end
  end

  // ============================================================
  // Reset and driver
  // ============================================================
  initial begin
    void'($urandom(SEED));
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_instr  = '0;
    out_ready = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_idle(1'b0);                      // Held in reset
    repeat (3) @(posedge clk);
    #2 rst_n = 1'b1;
    @(posedge clk);
    @(negedge clk);
    check_idle(1'b1);                      // Ready with nothing out yet
    @(posedge clk);
    #2;
    for (int i = 0; i < NUM_INSTR; i++) begin
      gap = $urandom_range(3);
      repeat (gap) begin
        @(posedge clk);
        #2;
      end
      in_instr = random_instr();
      in_valid = 1'b1;
      @(negedge clk);
      while (in_ready !== 1'b1)
        @(negedge clk);
      @(posedge clk);                      // Accepted here
      #2;
      in_valid = 1'b0;
    end
    while (exp_q.size() != 0)
      @(posedge clk);
    repeat (20) @(posedge clk);            // Catch any stray output
    @(negedge clk);
    if (out_valid !== 1'b0) begin
      $display("Output still valid after the last expected micro-op");
      $display("Verification failed");
      $fatal(1, "output left over at end");
    end else begin
      $display("%0d micro-ops checked", n_out);
      $display("Verification passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- micro_expand.f
+incdir+rtl
+incdir+sim
rtl/micro_expand_pkg.sv
rtl/dec_if.sv
rtl/macro_decode.sv
rtl/micro_code_rom.sv
rtl/micro_sequencer.sv
rtl/uop_output_buf.sv
rtl/micro_expand_top.sv
sim/tb_micro_expand.sv

//--- run_sim.sh
#!/bin/sh
# Build the expander testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps -f micro_expand.f \
    --top-module tb_micro_expand -o tb_micro_expand && \
  { ./obj_dir/tb_micro_expand > sim.log 2>&1 || true; } && \
  cat sim.log && \
  grep -q "^Verification passed$" sim.log && \
  echo "PASS" || { echo "FAIL"; exit 1; }
